/* hw/stepper_pkg.sv */
package stepper_pkg;

  localparam int PWM_BITS = 8;

  typedef logic [31:0] word_t;  // One SPI word
  typedef logic [7:0] byte_t;
  typedef logic [31:0] duration_t;  // Move length in CLK cycles
  typedef logic [23:0] divisor_t;  // CLK cycles per step
  typedef logic [1:0] ustep_t;  // Microstep exponent
  typedef logic signed [15:0] pos_t;  // Rotor position in table units
  typedef logic [PWM_BITS-1:0] pwm_t;

  // Command headers in the top byte of a word
  localparam byte_t HDR_MOVE = 8'd1;
  localparam byte_t HDR_DIR = 8'd2;
  localparam byte_t HDR_DIVISOR = 8'd3;
  localparam byte_t HDR_USTEP = 8'd4;

  localparam divisor_t DIVISOR_RESET = 24'd50000;
  localparam ustep_t USTEP_RESET = 2'd0;

  // Quarter sine sampled mid-interval so entry 7-i gives the cosine
  localparam pwm_t MAG_TABLE [0:7] = '{
    8'd25,
    8'd74,
    8'd120,
    8'd162,
    8'd197,
    8'd225,
    8'd244,
    8'd254
  };

  typedef enum logic {
    DEC_HEADER,
    DEC_PAYLOAD
  } dec_state_t;

endpackage

/* hw/spi_slave.sv */
`timescale 1ns/1ps

module spi_slave (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               sck,
  input  logic               ssel,
  input  logic               mosi,
  output logic               miso,
  input  stepper_pkg::byte_t tx_byte,
  output logic               byte_valid,
  output stepper_pkg::byte_t byte_data,
  output logic               ssel_active
);

  logic [2:0] sck_sync;  // Two sync flops plus one for edge detect
  logic [2:0] ssel_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       ssel_start;
  logic [2:0] bit_cnt;
  stepper_pkg::byte_t rx_shift;
  stepper_pkg::byte_t tx_shift;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      ssel_sync <= '1;  // Deselected
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      ssel_sync <= {ssel_sync[1:0], ssel};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise    = sck_sync[1] & ~sck_sync[2];
  assign sck_fall    = ~sck_sync[1] & sck_sync[2];
  assign ssel_start  = ~ssel_sync[1] & ssel_sync[2];
  assign ssel_active = ~ssel_sync[1];
  assign miso        = tx_shift[7];  // MSB first

  // Bit counter and byte strobe
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!ssel_active) begin
        bit_cnt <= '0;  // Abort partial byte
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) byte_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ssel_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) byte_data <= {rx_shift[6:0], mosi_sync[1]};
    end
  end

  // Mode 0 output puts the first bit on the pin before the first rising edge
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (ssel_start) begin
      tx_shift <= tx_byte;
    end else if (!ssel_active) begin
      tx_shift <= '0;  // Idle low
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0) tx_shift <= tx_byte;  // Byte boundary
      else tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

endmodule

/* hw/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               byte_valid,
  input  stepper_pkg::byte_t byte_data,
  input  logic               ssel_active,
  output stepper_pkg::byte_t tx_byte,
  input  logic               busy,
  input  stepper_pkg::pos_t  position,
  output logic               word_valid,
  output stepper_pkg::word_t word_data,
  output logic               led
);

  logic [1:0]         byte_idx;
  logic [23:0]        low_bytes;  // First three bytes of the word
  stepper_pkg::word_t status_q;
  logic               last_byte;

  assign last_byte = byte_valid && (byte_idx == 2'd3);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      byte_idx   <= '0;
      word_valid <= 1'b0;
      led        <= 1'b0;
    end else begin
      word_valid <= last_byte;
      if (!ssel_active) byte_idx <= '0;
      else if (byte_valid) byte_idx <= byte_idx + 2'd1;
      if (word_valid) led <= ~led;  // Activity blink
    end
  end

  // Least significant byte arrives first
  always_ff @(posedge CLK) begin
    if (byte_valid) begin
      if (byte_idx != 2'd3) low_bytes[{byte_idx, 3'b000} +: 8] <= byte_data;
      else word_data <= {byte_data, low_bytes};
    end
  end

  // Status follows live values while idle and freezes for the word in flight
  always_ff @(posedge CLK) begin
    if (!ssel_active || last_byte) begin
      status_q <= {busy, 15'd0, position};
    end
  end

  assign tx_byte = status_q[{byte_idx, 3'b000} +: 8];

endmodule

/* hw/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   word_valid,
  input  stepper_pkg::word_t     word_data,
  output logic                   move_start,
  output stepper_pkg::duration_t move_duration,
  output stepper_pkg::divisor_t  divisor,
  output logic                   dir,
  output stepper_pkg::ustep_t    ustep
);

  stepper_pkg::dec_state_t state;
  stepper_pkg::byte_t      header;

  assign header = word_data[31:24];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= stepper_pkg::DEC_HEADER;
      move_start <= 1'b0;
      divisor    <= stepper_pkg::DIVISOR_RESET;
      dir        <= 1'b0;
      ustep      <= stepper_pkg::USTEP_RESET;
    end else begin
      move_start <= 1'b0;
      if (word_valid) begin
        case (state)
          stepper_pkg::DEC_HEADER: begin
            case (header)
              stepper_pkg::HDR_MOVE: begin
                state <= stepper_pkg::DEC_PAYLOAD;  // Duration follows
              end
              stepper_pkg::HDR_DIR: begin
                dir <= word_data[0];
              end
              stepper_pkg::HDR_DIVISOR: begin
                divisor <= word_data[23:0];
              end
              stepper_pkg::HDR_USTEP: begin
                ustep <= word_data[1:0];
              end
              default: begin
                state <= stepper_pkg::DEC_HEADER;  // Unknown header dropped
              end
            endcase
          end
          stepper_pkg::DEC_PAYLOAD: begin
            move_start <= 1'b1;
            state      <= stepper_pkg::DEC_HEADER;
          end
          default: begin
            state <= stepper_pkg::DEC_HEADER;
          end
        endcase
      end
    end
  end

  // Duration held until the next move word
  always_ff @(posedge CLK) begin
    if (word_valid && state == stepper_pkg::DEC_PAYLOAD) begin
      move_duration <= word_data;
    end
  end

endmodule

/* hw/step_generator.sv */
`timescale 1ns/1ps

module step_generator (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   move_start,
  input  stepper_pkg::duration_t move_duration,
  input  stepper_pkg::divisor_t  divisor,
  output logic                   step,
  output logic                   busy
);

  stepper_pkg::duration_t elapsed;  // Busy cycle number from 1
  stepper_pkg::divisor_t  intra;    // Cycle within the current step period
  logic                   step_due;

  // Compare with >= so a divisor lowered mid-move still steps
  assign step_due = (divisor != '0) && (intra >= divisor);
  assign step     = busy && step_due;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      elapsed <= '0;
      intra   <= '0;
    end else if (move_start) begin
      // Restarts a running move as well
      busy    <= (move_duration != '0);
      elapsed <= 32'd1;
      intra   <= 24'd1;
    end else if (busy) begin
      if (elapsed == move_duration) begin
        busy <= 1'b0;
      end
      elapsed <= elapsed + 32'd1;
      if (step_due) intra <= 24'd1;
      else intra <= intra + 24'd1;
    end else begin
      elapsed <= '0;
      intra   <= '0;
    end
  end

endmodule

/* hw/phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                step,
  input  logic                dir,
  input  stepper_pkg::ustep_t ustep,
  output stepper_pkg::pos_t   position,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                pwm_a,
  output logic                pwm_b
);

  stepper_pkg::pos_t delta;
  logic              energized;  // Coils stay off until the first step
  stepper_pkg::pwm_t pwm_cnt;
  logic [1:0]        quadrant;
  logic [2:0]        angle;
  stepper_pkg::pwm_t mag_a;
  stepper_pkg::pwm_t mag_b;

  // Full step is 8 table units
  assign delta = stepper_pkg::pos_t'(16'd8 >> ustep);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      position  <= '0;
      energized <= 1'b0;
      pwm_cnt   <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      if (step) begin
        energized <= 1'b1;
        position  <= dir ? position - delta : position + delta;
      end
    end
  end

  // 32 table units per electrical cycle
  assign quadrant = position[4:3];
  assign angle    = position[2:0];
  assign mag_a    = stepper_pkg::MAG_TABLE[angle];
  assign mag_b    = stepper_pkg::MAG_TABLE[3'd7 - angle];  // Cosine

  always_comb begin
    phase_a1 = 1'b0;
    phase_a2 = 1'b0;
    phase_b1 = 1'b0;
    phase_b2 = 1'b0;
    if (energized) begin
      case (quadrant)
        2'd0: {phase_a1, phase_b1} = 2'b11;
        2'd1: {phase_a2, phase_b1} = 2'b11;
        2'd2: {phase_a2, phase_b2} = 2'b11;
        default: {phase_a1, phase_b2} = 2'b11;
      endcase
    end
  end

  assign pwm_a = energized && (pwm_cnt < mag_a);
  assign pwm_b = energized && (pwm_cnt < mag_b);

endmodule

/* hw/stepper_top.sv */
`timescale 1ns/1ps

module stepper_top (
  input  logic CLK,
  input  logic rst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic led,
  output logic busy,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b
);

  stepper_pkg::byte_t     tx_byte;
  logic                   byte_valid;
  stepper_pkg::byte_t     byte_data;
  logic                   ssel_active;
  logic                   word_valid;
  stepper_pkg::word_t     word_data;
  logic                   move_start;
  stepper_pkg::duration_t move_duration;
  stepper_pkg::divisor_t  divisor;
  logic                   dir;
  stepper_pkg::ustep_t    ustep;
  logic                   step;
  stepper_pkg::pos_t      position;

  spi_slave u_spi (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .tx_byte(tx_byte), .byte_valid(byte_valid), .byte_data(byte_data),
    .ssel_active(ssel_active)
  );

  word_assembler u_words (
    .CLK(CLK), .rst_n(rst_n), .byte_valid(byte_valid), .byte_data(byte_data),
    .ssel_active(ssel_active), .tx_byte(tx_byte), .busy(busy), .position(position),
    .word_valid(word_valid), .word_data(word_data), .led(led)
  );

  cmd_decoder u_dec (
    .CLK(CLK), .rst_n(rst_n), .word_valid(word_valid), .word_data(word_data),
    .move_start(move_start), .move_duration(move_duration), .divisor(divisor),
    .dir(dir), .ustep(ustep)
  );

  step_generator u_stepgen (
    .CLK(CLK), .rst_n(rst_n), .move_start(move_start), .move_duration(move_duration),
    .divisor(divisor), .step(step), .busy(busy)
  );

  phase_sequencer u_phase (
    .CLK(CLK), .rst_n(rst_n), .step(step), .dir(dir), .ustep(ustep),
    .position(position), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b)
  );

endmodule

/* dv/tb_spi_tasks.svh */
localparam int SCK_HALF = 8;  // CLK cycles per SCK half period

task automatic wait_clocks(input int n);
  repeat (n) @(posedge CLK);
  #1;  // Drive just after the edge
endtask

// Full duplex word that returns what the slave shifted out
task automatic spi_transfer(input stepper_pkg::word_t tx_word,
                            output stepper_pkg::word_t rx_word);
  stepper_pkg::byte_t tx_b;
  stepper_pkg::byte_t rx_b;
  ssel = 1'b0;
  wait_clocks(SCK_HALF);  // Slave syncs ssel and loads its first byte
  for (int b = 0; b < 4; b++) begin
    tx_b = tx_word[b*8 +: 8];
    for (int i = 7; i >= 0; i--) begin
      mosi = tx_b[i];  // Changed while SCK is low
      wait_clocks(SCK_HALF);
      sck     = 1'b1;
      rx_b[i] = miso;  // Steady across the rising edge
      wait_clocks(SCK_HALF);
      sck = 1'b0;
    end
    rx_word[b*8 +: 8] = rx_b;
  end
  mosi = 1'b0;
  wait_clocks(SCK_HALF);
  exp_led = ~exp_led;  // Every complete word toggles the activity LED
  ssel    = 1'b1;
  // Gap so the status snapshot follows live values again
  wait_clocks(SCK_HALF);
endtask

task automatic send_word(input stepper_pkg::word_t w);
  stepper_pkg::word_t ignored_rx;
  spi_transfer(w, ignored_rx);
endtask

// Header 0 is no command, so this word only reads the status back
task automatic read_status(output stepper_pkg::word_t status);
  spi_transfer(32'h0000_0000, status);
endtask

/* dv/tb_stepper.sv */
`timescale 1ns/1ps

module tb_stepper;

  localparam int NUM_MOVES = 12;
  // About 7 words of 560 cycles plus up to 2000 busy cycles per move
  localparam int TIMEOUT_CYCLES = 200000;

  logic CLK = 1'b0;
  logic rst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso, led, busy;
  logic phase_a1, phase_a2, phase_b1, phase_b2;
  logic pwm_a, pwm_b;

  // Expected values and check strobes
  int unsigned        exp_duration = 0;
  int                 exp_steps = 0;
  int                 exp_pos = 0;
  logic               exp_dir = 1'b0;
  logic               exp_led = 1'b0;
  logic               quad_check_en = 1'b0;
  logic               reset_window = 1'b0;
  logic               busy_chk = 1'b0;
  logic               pos_chk = 1'b0;
  logic               status_exp_busy = 1'b0;
  stepper_pkg::word_t status_got = '0;

  // Monitors
  int unsigned cycle_count = 0;
  int unsigned busy_len = 0;
  int          quad_changes = 0;
  logic        busy_q = 1'b0;
  logic        busy_fell;
  logic        busy_fell_q = 1'b0;
  logic [3:0]  phases;
  logic [3:0]  phases_q = '0;
  int          quad_now;
  int          quad_prev;
  logic        order_ok;

  stepper_top u_dut (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .led(led), .busy(busy), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b)
  );

  always #4 CLK = ~CLK;

  `include "tb_spi_tasks.svh"

  task automatic fail_now(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // Quadrant from the bridge levels {a1, a2, b1, b2} or -1 for no valid drive
  function automatic int quadrant_of(input logic [3:0] ph);
    case (ph)
      4'b1010: return 0;
      4'b0110: return 1;
      4'b0101: return 2;
      4'b1001: return 3;
      default: return -1;
    endcase
  endfunction

  // One strobe cycle for the status word assertions
  task automatic post_status_check(input stepper_pkg::word_t rx, input logic exp_busy,
                                   input logic check_pos);
    status_got      = rx;
    status_exp_busy = exp_busy;
    busy_chk        = 1'b1;
    pos_chk         = check_pos;
    wait_clocks(1);
    busy_chk = 1'b0;
    pos_chk  = 1'b0;
  endtask

  assign phases    = {phase_a1, phase_a2, phase_b1, phase_b2};
  assign busy_fell = busy_q && !busy;

  always_comb begin
    quad_now  = quadrant_of(phases);
    quad_prev = quadrant_of(phases_q);
    order_ok  = (quad_now == ((quad_prev + (exp_dir ? 3 : 1)) % 4));  // Reverse on dir 1
  end

  always @(posedge CLK) begin
    busy_q      <= busy;
    phases_q    <= phases;
    busy_fell_q <= busy_fell;
    if (busy) busy_len <= busy_len + 1;
    else busy_len <= 0;
    if (busy && !busy_q) quad_changes <= 0;  // New move window
    else if (phases != phases_q) quad_changes <= quad_changes + 1;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  a_reset_idle: assert property (@(posedge CLK) disable iff (!rst_n)
    reset_window |-> (phases == 4'b0000 && !busy && !miso))
    else fail_now("outputs not idle after reset");

  a_busy_len: assert property (@(posedge CLK) disable iff (!rst_n)
    busy_fell |-> busy_len == exp_duration)
    else fail_now($sformatf("busy high %0d cycles, expected %0d", busy_len, exp_duration));

  a_quad_count: assert property (@(posedge CLK) disable iff (!rst_n)
    (busy_fell_q && quad_check_en) |-> quad_changes == exp_steps)
    else fail_now($sformatf("%0d quadrant changes, expected %0d", quad_changes, exp_steps));

  a_phase_legal: assert property (@(posedge CLK) disable iff (!rst_n)
    (phases == 4'b0000) || (quad_now >= 0))
    else fail_now($sformatf("illegal phase pattern %b", phases));

  a_quad_order: assert property (@(posedge CLK) disable iff (!rst_n)
    (phases != phases_q && quad_prev >= 0) |-> order_ok)
    else fail_now($sformatf("quadrant went %0d to %0d with dir %0d", quad_prev, quad_now,
                            exp_dir));

  a_status_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    busy_chk |-> status_got[31] == status_exp_busy)
    else fail_now($sformatf("status busy bit %0d, expected %0d", status_got[31],
                            status_exp_busy));

  a_status_pos: assert property (@(posedge CLK) disable iff (!rst_n)
    pos_chk |-> status_got[15:0] == exp_pos[15:0])
    else fail_now($sformatf("status position %0d, expected %0d",
                            $signed(status_got[15:0]), exp_pos));

  a_pwm_a: assert property (@(posedge CLK) disable iff (!rst_n)
    pwm_a |-> (phase_a1 || phase_a2))
    else fail_now("pwm_a active with bridge A off");

  a_pwm_b: assert property (@(posedge CLK) disable iff (!rst_n)
    pwm_b |-> (phase_b1 || phase_b2))
    else fail_now("pwm_b active with bridge B off");

  // LED toggles once per received word, checked while deselected
  a_led: assert property (@(posedge CLK) disable iff (!rst_n)
    ssel |-> led == exp_led)
    else fail_now($sformatf("led %0d, expected %0d", led, exp_led));

  initial begin
    int unsigned         div_val;
    int unsigned         dur;
    int                  move_units;
    stepper_pkg::ustep_t ustep_val;
    stepper_pkg::word_t  rx;
    void'($urandom(32'hbc5ccb82));
    rst_n = 1'b0;
    sck   = 1'b0;
    ssel  = 1'b1;
    mosi  = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    rst_n        = 1'b1;
    reset_window = 1'b1;
    wait_clocks(16);
    reset_window = 1'b0;
    read_status(rx);
    post_status_check(rx, 1'b0, 1'b1);  // Idle at position 0

    for (int i = 0; i < NUM_MOVES; i++) begin
      div_val   = 4 + ($urandom % 37);
      dur       = 100 + ($urandom % 1901);
      ustep_val = (i < 4) ? 2'd0 : stepper_pkg::ustep_t'($urandom % 4);
      exp_dir   = (i < 4) ? (i % 2 == 1) : ($urandom % 2 == 1);  // Both ways in full step
      send_word({stepper_pkg::HDR_DIR, 23'd0, exp_dir});
      send_word({stepper_pkg::HDR_DIVISOR, div_val[23:0]});
      send_word({stepper_pkg::HDR_USTEP, 22'd0, ustep_val});
      exp_duration  = dur;
      exp_steps     = int'(dur / div_val);
      quad_check_en = (ustep_val == 2'd0);
      send_word({stepper_pkg::HDR_MOVE, 24'd0});
      send_word(dur);
      read_status(rx);
      post_status_check(rx, 1'b1, 1'b0);  // Snapshot taken mid-move
      while (busy) wait_clocks(1);
      wait_clocks(3);  // Let the step count settle
      move_units = exp_steps * (8 >> ustep_val);
      exp_pos    = exp_dir ? exp_pos - move_units : exp_pos + move_units;
      read_status(rx);
      post_status_check(rx, 1'b0, 1'b1);
    end

    wait_clocks(4);
    $display("Verification passed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+dv
hw/stepper_pkg.sv
hw/spi_slave.sv
hw/word_assembler.sv
hw/cmd_decoder.sv
hw/step_generator.sv
hw/phase_sequencer.sv
hw/stepper_top.sv
dv/tb_stepper.sv

/* run.sh */
#!/bin/sh
# Build and run the stepper controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stepper -f sim.f -o tb_stepper

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/tb_stepper
